// ==== codec_engine.sv ====
// Run-length codec engine
module codec_engine #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  logic             m_enable_i,
   input  logic [23:0]      dc_i,
   input  codec_pkg::word_t m_src_i,
   input  logic             m_src_last_i,
   input  logic             m_src_empty_i,
   input  logic             m_dst_full_i,
   output logic             m_src_getn_o,
   output logic             m_dst_putn_o,
   output codec_pkg::word_t m_dst_o,
   output logic             m_dst_last_o,
   output logic             m_endn_o
);
   import codec_pkg::*;

   logic  enc_ce;
   logic  dec_ce;
   logic  enc_getn;
   logic  dec_getn;
   logic  enc_wr;
   logic  dec_wr;
   unit_t enc_unit;
   unit_t dec_unit;
   logic  enc_last;
   logic  dec_last;
   logic  fifo_wr;
   unit_t fifo_unit;
   logic  fifo_last;
   logic  almost_full;
   logic  rd;
   unit_t rd_unit;
   logic  rd_last;
   logic  not_empty;

   // Encode has priority when both mode bits are set
   assign enc_ce = dc_i[MODE_ENC_BIT] & m_enable_i;
   assign dec_ce = dc_i[MODE_DEC_BIT] & m_enable_i & ~dc_i[MODE_ENC_BIT];

   // Idle codec keeps getn high and its write outputs at zero
   assign m_src_getn_o = enc_getn & dec_getn;
   assign fifo_wr      = enc_wr | dec_wr;
   assign fifo_unit    = enc_unit | dec_unit;
   assign fifo_last    = enc_last | dec_last;

   rle_encode u_encode (
      .wb_clk_i           (wb_clk_i),
      .rst_n_i            (rst_n_i),
      .ce_i               (enc_ce),
      .m_src_i            (m_src_i),
      .m_src_last_i       (m_src_last_i),
      .m_src_empty_i      (m_src_empty_i),
      .fifo_almost_full_i (almost_full),
      .m_src_getn_o       (enc_getn),
      .wr_o               (enc_wr),
      .wr_unit_o          (enc_unit),
      .wr_last_o          (enc_last)
   );

   rle_decode u_decode (
      .wb_clk_i           (wb_clk_i),
      .rst_n_i            (rst_n_i),
      .ce_i               (dec_ce),
      .m_src_i            (m_src_i),
      .m_src_last_i       (m_src_last_i),
      .m_src_empty_i      (m_src_empty_i),
      .fifo_almost_full_i (almost_full),
      .m_src_getn_o       (dec_getn),
      .wr_o               (dec_wr),
      .wr_unit_o          (dec_unit),
      .wr_last_o          (dec_last)
   );

   unit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .wb_clk_i      (wb_clk_i),
      .rst_n_i       (rst_n_i),
      .wr_i          (fifo_wr),
      .wr_unit_i     (fifo_unit),
      .wr_last_i     (fifo_last),
      .rd_i          (rd),
      .rd_unit_o     (rd_unit),
      .rd_last_o     (rd_last),
      .not_empty_o   (not_empty),
      .almost_full_o (almost_full)
   );

   codeout u_codeout (
      .wb_clk_i     (wb_clk_i),
      .rst_n_i      (rst_n_i),
      .rd_unit_i    (rd_unit),
      .rd_last_i    (rd_last),
      .not_empty_i  (not_empty),
      .m_dst_full_i (m_dst_full_i),
      .rd_o         (rd),
      .m_dst_o      (m_dst_o),
      .m_dst_putn_o (m_dst_putn_o),
      .m_dst_last_o (m_dst_last_o),
      .m_endn_o     (m_endn_o)
   );

endmodule

// ==== codec_engine_assertions.sv ====
// Engine FIFO strobe checks
module codec_engine_assertions (
   input logic wb_clk_i,
   input logic rst_n_i,
   input logic src_empty_i,
   input logic src_getn_i,
   input logic dst_full_i,
   input logic dst_putn_i,
   input logic dst_last_i,
   input logic endn_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // Pops only from a source that has data, one cycle per word
   a_getn_not_empty: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !src_getn_i |-> (!src_empty_i && $past(src_getn_i)))
      else $error("source pop while empty or held low for two cycles");

   // Puts only into a destination with room
   a_putn_not_full: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !dst_putn_i |-> !dst_full_i)
      else $error("destination put while the destination FIFO is full");

   // Job end marks the put of the last word and lasts one cycle
   a_endn_with_last: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
      !endn_i |-> (!dst_putn_i && dst_last_i && $past(endn_i)))
      else $error("job end without a put of the last word or longer than one cycle");

endmodule

// ==== codec_pkg.sv ====
// Codec shared definitions
package codec_pkg;

   // Source and destination FIFO word
   typedef logic [63:0] word_t;

   // One run token or one pair of decoded bytes
   typedef logic [15:0] unit_t;

   // Single data byte
   typedef logic [7:0] byte_t;

   // Run count held in a token's upper byte
   typedef logic [7:0] count_t;

   // Mode bits in the command word
   localparam int MODE_ENC_BIT = 5;
   localparam int MODE_DEC_BIT = 6;

   // Longest run one token can describe
   localparam int MAX_RUN = 255;

endpackage

// ==== codeout.sv ====
// Output word packer
module codeout (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  codec_pkg::unit_t rd_unit_i,
   input  logic             rd_last_i,
   input  logic             not_empty_i,
   input  logic             m_dst_full_i,
   output logic             rd_o,
   output codec_pkg::word_t m_dst_o,
   output logic             m_dst_putn_o,
   output logic             m_dst_last_o,
   output logic             m_endn_o
);
   import codec_pkg::*;

   word_t      acc;
   word_t      packed_word;
   logic [1:0] unit_cnt;
   logic       word_ready;
   logic       word_last;
   logic       put;
   logic       word_done;

   assign put = word_ready && !m_dst_full_i;

   // A unit may enter while the finished word leaves in the same cycle
   assign rd_o = not_empty_i && (!word_ready || !m_dst_full_i);

   assign word_done = (unit_cnt == 2'd3) || rd_last_i;

   // Left-align the collected units, zero units fill the tail
   assign packed_word = {acc[47:0], rd_unit_i} << (16 * (3 - unit_cnt));

   assign m_dst_putn_o = !put;
   assign m_dst_last_o = word_last;
   assign m_endn_o     = !(put && word_last);

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         unit_cnt   <= '0;
         word_ready <= 1'b0;
         word_last  <= 1'b0;
      end else begin
         if (put) begin
            word_ready <= 1'b0;
            word_last  <= 1'b0;
         end
         if (rd_o) begin
            if (word_done) begin
               word_ready <= 1'b1;
               word_last  <= rd_last_i;
               unit_cnt   <= '0;
            end else begin
               unit_cnt <= unit_cnt + 2'd1;
            end
         end
      end
   end

   // Shift register and output word
   always_ff @(posedge wb_clk_i) begin
      if (rd_o) begin
         acc <= {acc[47:0], rd_unit_i};
         if (word_done) begin
            m_dst_o <= packed_word;
         end
      end
   end

endmodule

// ==== flist.f ====
codec_pkg.sv
rle_encode.sv
rle_decode.sv
unit_fifo.sv
codeout.sv
codec_engine.sv
codec_engine_assertions.sv
tb_codec_engine.sv

// ==== rle_decode.sv ====
// Run-length token decoder
module rle_decode (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  logic             ce_i,
   input  codec_pkg::word_t m_src_i,
   input  logic             m_src_last_i,
   input  logic             m_src_empty_i,
   input  logic             fifo_almost_full_i,
   output logic             m_src_getn_o,
   output logic             wr_o,
   output codec_pkg::unit_t wr_unit_o,
   output logic             wr_last_o
);
   import codec_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      FLUSH
   } dec_state_t;

   dec_state_t state;
   logic [1:0] tok_idx;
   unit_t      tok;
   count_t     tok_cnt;
   byte_t      tok_byte;
   count_t     rep;
   logic       tok_done;
   logic       step;
   byte_t      hi_byte;
   logic       have_hi;
   unit_t      hold_unit;
   logic       hold_valid;

   assign tok      = m_src_i[16*(3-tok_idx) +: 16];
   assign tok_cnt  = tok[15:8];
   assign tok_byte = tok[7:0];

   // Zero tokens are padding and finish at once
   assign tok_done = (tok_cnt == '0) || ((rep + 8'd1) == tok_cnt);
   assign step     = (state == RUN) && !m_src_empty_i && !fifo_almost_full_i;

   assign m_src_getn_o = !(step && (tok_idx == 2'd3) && tok_done);

   // Completed units wait one step in hold_unit so the final one can carry the tag
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         state      <= IDLE;
         tok_idx    <= '0;
         rep        <= '0;
         have_hi    <= 1'b0;
         hold_valid <= 1'b0;
         wr_o       <= 1'b0;
         wr_unit_o  <= '0;
         wr_last_o  <= 1'b0;
      end else begin
         wr_o      <= 1'b0;
         wr_unit_o <= '0;
         wr_last_o <= 1'b0;
         case (state)
            IDLE: begin
               if (ce_i && !m_src_empty_i) begin
                  state   <= RUN;
                  tok_idx <= '0;
                  rep     <= '0;
               end
            end
            RUN: begin
               if (step) begin
                  if (tok_cnt != '0) begin
                     if (have_hi) begin
                        // Low byte closes a pair
                        have_hi    <= 1'b0;
                        hold_unit  <= {hi_byte, tok_byte};
                        hold_valid <= 1'b1;
                        if (hold_valid) begin
                           wr_o      <= 1'b1;
                           wr_unit_o <= hold_unit;
                        end
                     end else begin
                        hi_byte <= tok_byte;
                        have_hi <= 1'b1;
                     end
                  end
                  if (tok_done) begin
                     rep     <= '0;
                     tok_idx <= tok_idx + 2'd1;
                     if ((tok_idx == 2'd3) && m_src_last_i) begin
                        state <= FLUSH;
                     end
                  end else begin
                     rep <= rep + 8'd1;
                  end
               end
            end
            FLUSH: begin
               if (!fifo_almost_full_i) begin
                  wr_o <= 1'b1;
                  if (have_hi && hold_valid) begin
                     // Held unit goes first, odd byte stays for the tag
                     wr_unit_o <= hold_unit;
                     hold_unit <= {hi_byte, 8'h00};
                     have_hi   <= 1'b0;
                  end else begin
                     wr_last_o  <= 1'b1;
                     wr_unit_o  <= have_hi ? {hi_byte, 8'h00} :
                                   (hold_valid ? hold_unit : '0);
                     have_hi    <= 1'b0;
                     hold_valid <= 1'b0;
                     state      <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== rle_encode.sv ====
// Run-length byte encoder
module rle_encode (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  logic             ce_i,
   input  codec_pkg::word_t m_src_i,
   input  logic             m_src_last_i,
   input  logic             m_src_empty_i,
   input  logic             fifo_almost_full_i,
   output logic             m_src_getn_o,
   output logic             wr_o,
   output codec_pkg::unit_t wr_unit_o,
   output logic             wr_last_o
);
   import codec_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      SCAN,
      FLUSH
   } enc_state_t;

   enc_state_t state;
   logic [2:0] byte_idx;
   byte_t      cur_byte;
   byte_t      run_byte;
   count_t     run_cnt;
   logic       step;
   logic       merge;
   logic       close_run;

   // Byte under the index, first byte sits in the top lane
   assign cur_byte = m_src_i[8*(7-byte_idx) +: 8];

   // One byte per cycle while data is there and the buffer has room
   assign step = (state == SCAN) && !m_src_empty_i && !fifo_almost_full_i;

   // Same byte extends the run until the count saturates
   assign merge = (run_cnt != '0) && (cur_byte == run_byte) &&
                  (run_cnt != count_t'(MAX_RUN));
   assign close_run = (run_cnt != '0) && !merge;

   // Pop the head word together with its eighth byte
   assign m_src_getn_o = !(step && (byte_idx == 3'd7));

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         state     <= IDLE;
         byte_idx  <= '0;
         run_cnt   <= '0;
         wr_o      <= 1'b0;
         wr_unit_o <= '0;
         wr_last_o <= 1'b0;
      end else begin
         // Write outputs idle at zero, they are ORed with the decoder
         wr_o      <= 1'b0;
         wr_unit_o <= '0;
         wr_last_o <= 1'b0;
         case (state)
            IDLE: begin
               if (ce_i && !m_src_empty_i) begin
                  state    <= SCAN;
                  byte_idx <= '0;
                  run_cnt  <= '0;
               end
            end
            SCAN: begin
               if (step) begin
                  if (close_run) begin
                     wr_o      <= 1'b1;
                     wr_unit_o <= {run_cnt, run_byte};
                  end
                  run_cnt  <= merge ? run_cnt + 8'd1 : 8'd1;
                  byte_idx <= byte_idx + 3'd1;
                  if ((byte_idx == 3'd7) && m_src_last_i) begin
                     state <= FLUSH;
                  end
               end
            end
            FLUSH: begin
               // Open run becomes the tagged final token
               if (!fifo_almost_full_i) begin
                  wr_o      <= 1'b1;
                  wr_unit_o <= {run_cnt, run_byte};
                  wr_last_o <= 1'b1;
                  run_cnt   <= '0;
                  state     <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Run value
   always_ff @(posedge wb_clk_i) begin
      if (step) begin
         run_byte <= cur_byte;
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the codec engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_codec_engine -o sim_codec
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_codec > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
   exit 0
fi
exit 1

// ==== tb_codec_engine.sv ====
// Codec engine testbench
module tb_codec_engine;
   timeunit 1ns;
   timeprecision 1ps;

   import codec_pkg::*;

   logic        clk;
   logic        rst_n;
   logic        m_enable;
   logic [23:0] dc;
   word_t       m_src;
   logic        m_src_last;
   logic        m_src_empty;
   logic        m_dst_full;
   logic        m_src_getn;
   logic        m_dst_putn;
   word_t       m_dst;
   logic        m_dst_last;
   logic        m_endn;

   // Source FIFO model, bit 64 flags the last word of a job
   logic [64:0] src_q[$];
   word_t       got_q[$];
   logic        got_last_q[$];

   int    endn_cnt;
   int    proto_errs;
   int    cycle_cnt;
   int    cycle_limit;
   bit    stall_en;
   int    test_cnt;
   int    fail_cnt;
   int    j;
   byte_t data[$];

   codec_engine #(
      .FIFO_DEPTH (8)
   ) UUT (
      .wb_clk_i      (clk),
      .rst_n_i       (rst_n),
      .m_enable_i    (m_enable),
      .dc_i          (dc),
      .m_src_i       (m_src),
      .m_src_last_i  (m_src_last),
      .m_src_empty_i (m_src_empty),
      .m_dst_full_i  (m_dst_full),
      .m_src_getn_o  (m_src_getn),
      .m_dst_putn_o  (m_dst_putn),
      .m_dst_o       (m_dst),
      .m_dst_last_o  (m_dst_last),
      .m_endn_o      (m_endn)
   );

   bind codec_engine codec_engine_assertions u_sva (
      .wb_clk_i    (wb_clk_i),
      .rst_n_i     (rst_n_i),
      .src_empty_i (m_src_empty_i),
      .src_getn_i  (m_src_getn_o),
      .dst_full_i  (m_dst_full_i),
      .dst_putn_i  (m_dst_putn_o),
      .dst_last_i  (m_dst_last_o),
      .endn_i      (m_endn_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Source head and destination full change on the falling edge
   always @(negedge clk) begin
      if (src_q.size() != 0) begin
         m_src       = src_q[0][63:0];
         m_src_last  = src_q[0][64];
         m_src_empty = 1'b0;
      end else begin
         m_src       = '0;
         m_src_last  = 1'b0;
         m_src_empty = 1'b1;
      end
      m_dst_full = stall_en && ($urandom % 3 == 0);
   end

   // Strobes act on the rising edge
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout after %0d cycles, a job did not finish", cycle_cnt);
         $display("TB FAILED");
         $finish;
      end else if (rst_n) begin
         if (!m_src_getn) begin
            if (m_src_empty) begin
               $display("%0t: engine popped the source while it was empty", $time);
               proto_errs++;
            end
            if (src_q.size() != 0) begin
               src_q.delete(0);
            end
         end
         if (!m_dst_putn) begin
            if (m_dst_full) begin
               $display("%0t: engine put a word while the destination was full", $time);
               proto_errs++;
            end
            got_q.push_back(m_dst);
            got_last_q.push_back(m_dst_last);
         end
         if (!m_endn) begin
            if (m_dst_putn || !m_dst_last) begin
               $display("%0t: job end came without a put of the last word", $time);
               proto_errs++;
            end
            endn_cnt++;
         end
      end
   end

   task automatic report_test(input string name, input int errs);
      test_cnt++;
      if (errs == 0) begin
         $display("PASS %s", name);
      end else begin
         $display("FAIL %s with %0d errors", name, errs);
         fail_cnt++;
      end
   endtask

   // Random bytes, three in four repeat the previous one
   task automatic make_bytes(input int n, output byte_t bytes[$]);
      byte_t b;
      int    i;
      bytes = {};
      b = byte_t'($urandom);
      for (i = 0; i < n; i++) begin
         if ($urandom % 4 == 0) begin
            b = byte_t'($urandom % 8);
         end
         bytes.push_back(b);
      end
   endtask

   // Runs close on a new byte value or at the longest run
   task automatic encode_model(input byte_t bytes[$], output unit_t toks[$]);
      byte_t val;
      int    cnt;
      int    i;
      toks = {};
      val = '0;
      cnt = 0;
      for (i = 0; i < bytes.size(); i++) begin
         if ((cnt != 0) && (bytes[i] == val) && (cnt < MAX_RUN)) begin
            cnt++;
         end else begin
            if (cnt != 0) begin
               toks.push_back({count_t'(cnt), val});
            end
            val = bytes[i];
            cnt = 1;
         end
      end
      if (cnt != 0) begin
         toks.push_back({count_t'(cnt), val});
      end
   endtask

   // Four units per word, first unit on top, zero units pad the tail
   task automatic pack_units(input unit_t units[$], output word_t words[$]);
      word_t w;
      int    n;
      int    i;
      words = {};
      w = '0;
      n = 0;
      for (i = 0; i < units.size(); i++) begin
         w[63-16*n -: 16] = units[i];
         n++;
         if (n == 4) begin
            words.push_back(w);
            w = '0;
            n = 0;
         end
      end
      if (n != 0) begin
         words.push_back(w);
      end
   endtask

   task automatic run_job(input string name, input int mode_bit, input word_t words[$],
                          input word_t exp_q[$], input int job_bytes);
      int   ends_before;
      int   proto_before;
      int   errs;
      int   i;
      logic last_w;
      errs = 0;
      got_q.delete();
      got_last_q.delete();
      ends_before  = endn_cnt;
      proto_before = proto_errs;
      cycle_limit += 40 * job_bytes;
      @(negedge clk);
      dc           = '0;
      dc[mode_bit] = 1'b1;
      m_enable     = 1'b1;
      @(posedge clk);
      for (i = 0; i < words.size(); i++) begin
         last_w = (i == words.size() - 1);
         src_q.push_back({last_w, words[i]});
      end
      while (endn_cnt == ends_before) begin
         @(negedge clk);
      end
      // Window for stray words after the job end
      repeat (20) @(negedge clk);
      if (got_q.size() != exp_q.size()) begin
         $display("** Error %s: word count expected %0d, actual %0d",
                  name, exp_q.size(), got_q.size());
         errs++;
      end
      for (i = 0; (i < exp_q.size()) && (i < got_q.size()); i++) begin
         if (got_q[i] !== exp_q[i]) begin
            $display("** Error %s: word %0d expected %h, actual %h",
                     name, i, exp_q[i], got_q[i]);
            errs++;
         end
         last_w = (i == exp_q.size() - 1);
         if (got_last_q[i] !== last_w) begin
            $display("** Error %s: last flag of word %0d expected %0b, actual %0b",
                     name, i, last_w, got_last_q[i]);
            errs++;
         end
      end
      if (endn_cnt - ends_before != 1) begin
         $display("** Error %s: end pulses expected 1, actual %0d",
                  name, endn_cnt - ends_before);
         errs++;
      end
      if (src_q.size() != 0) begin
         $display("%s: %0d source words were left unread", name, src_q.size());
         errs++;
      end
      errs += proto_errs - proto_before;
      report_test(name, errs);
   endtask

   task automatic encode_job(input string name, input byte_t bytes[$]);
      unit_t toks[$];
      word_t words[$];
      word_t exp_q[$];
      word_t w;
      int    i;
      words = {};
      w = '0;
      for (i = 0; i < bytes.size(); i++) begin
         w[63-8*(i%8) -: 8] = bytes[i];
         if (i % 8 == 7) begin
            words.push_back(w);
         end
      end
      encode_model(bytes, toks);
      pack_units(toks, exp_q);
      run_job(name, MODE_ENC_BIT, words, exp_q, bytes.size());
   endtask

   // Source tokens carry random zero padding tokens
   task automatic decode_job(input string name, input byte_t bytes[$]);
      unit_t toks[$];
      unit_t src_units[$];
      unit_t pairs[$];
      word_t words[$];
      word_t exp_q[$];
      int    i;
      src_units = {};
      pairs = {};
      encode_model(bytes, toks);
      for (i = 0; i < toks.size(); i++) begin
         if ($urandom % 4 == 0) begin
            src_units.push_back('0);
         end
         src_units.push_back(toks[i]);
      end
      pack_units(src_units, words);
      for (i = 0; i < bytes.size(); i += 2) begin
         pairs.push_back({bytes[i], (i + 1 < bytes.size()) ? bytes[i+1] : 8'h00});
      end
      pack_units(pairs, exp_q);
      run_job(name, MODE_DEC_BIT, words, exp_q, bytes.size());
   endtask

   // Engine stays silent with the mode bit set but enable low
   task automatic idle_test();
      int errs;
      int i;
      errs = 0;
      @(posedge clk);
      src_q.push_back({1'b1, 64'h0123456789abcdef});
      @(negedge clk);
      dc                = '0;
      dc[MODE_ENC_BIT]  = 1'b1;
      m_enable          = 1'b0;
      for (i = 0; i < 50; i++) begin
         @(negedge clk);
         if (!m_src_getn || !m_dst_putn || !m_endn) begin
            $display("idle_disabled: a FIFO strobe went low while the engine was disabled");
            errs++;
         end
      end
      if (got_q.size() != 0) begin
         $display("idle_disabled: %0d words appeared while disabled", got_q.size());
         errs++;
      end
      @(posedge clk);
      src_q.delete();
      report_test("idle_disabled", errs);
   endtask

   initial begin
      void'($urandom(32'h8cad46d0));
      rst_n       = 1'b0;
      m_enable    = 1'b0;
      dc          = '0;
      m_src       = '0;
      m_src_last  = 1'b0;
      m_src_empty = 1'b1;
      m_dst_full  = 1'b0;
      endn_cnt    = 0;
      proto_errs  = 0;
      cycle_cnt   = 0;
      cycle_limit = 2000;
      stall_en    = 1'b0;
      test_cnt    = 0;
      fail_cnt    = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      idle_test();
      for (j = 0; j < 4; j++) begin
         @(posedge clk);
         make_bytes(8 * (1 + int'($urandom % 12)), data);
         encode_job($sformatf("encode_random_%0d", j), data);
      end

      // 336 bytes with a run of 330 that needs two tokens
      @(posedge clk);
      make_bytes(6, data);
      for (j = 0; j < 330; j++) begin
         data.push_back(8'hc3);
      end
      encode_job("encode_long_run", data);

      for (j = 0; j < 3; j++) begin
         @(posedge clk);
         make_bytes(1 + int'($urandom % 120), data);
         decode_job($sformatf("decode_random_%0d", j), data);
      end
      @(posedge clk);
      make_bytes(37, data);
      decode_job("decode_odd_total", data);

      @(posedge clk);
      stall_en = 1'b1;
      for (j = 0; j < 3; j++) begin
         @(posedge clk);
         make_bytes(8 * (1 + int'($urandom % 12)), data);
         encode_job($sformatf("encode_stall_%0d", j), data);
         @(posedge clk);
         make_bytes(1 + int'($urandom % 120), data);
         decode_job($sformatf("decode_stall_%0d", j), data);
      end
      stall_en = 1'b0;

      $display("Tests run %0d, passed %0d, failed %0d",
               test_cnt, test_cnt - fail_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== unit_fifo.sv ====
// Tagged unit FIFO
module unit_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic             wb_clk_i,
   input  logic             rst_n_i,
   input  logic             wr_i,
   input  codec_pkg::unit_t wr_unit_i,
   input  logic             wr_last_i,
   input  logic             rd_i,
   output codec_pkg::unit_t rd_unit_o,
   output logic             rd_last_o,
   output logic             not_empty_o,
   output logic             almost_full_o
);
   import codec_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   // Entry is the last tag above the unit
   logic [16:0]   mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;

   assign rd_unit_o     = unit_t'(mem[rd_ptr][15:0]);
   assign rd_last_o     = mem[rd_ptr][16];
   assign not_empty_o   = (count != '0);
   // One free entry left covers a write already in flight
   assign almost_full_o = (count >= CW'(FIFO_DEPTH - 1));

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_i) begin
            wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
         end
         if (rd_i) begin
            rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
         end
         if (wr_i && !rd_i) begin
            count <= count + CW'(1);
         end else if (rd_i && !wr_i) begin
            count <= count - CW'(1);
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wr_i) begin
         mem[wr_ptr] <= {wr_last_i, wr_unit_i};
      end
   end

endmodule
